//--- src.f
+incdir+tests
common/smpc_pkg.sv
verilog/smpc_oreg_ram.sv
verilog/smpc_host_regs.sv
command/smpc_cmd_seq.sv
rtc/smpc_rtc.sv
verilog/smpc_top.sv
tests/tb_clock.sv
tests/smpc_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module smpc_tb -f src.f -o smpc_sim
./obj_dir/smpc_sim > sim.log
cat sim.log

if grep -q "Regression passed" sim.log; then
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

//--- tests/smpc_tb_tasks.svh
`ifndef SMPC_TB_TASKS_SVH
`define SMPC_TB_TASKS_SVH

localparam int POLL_LIMIT = 2000; // SF polls before a command is given up

function automatic smpc_pkg::addr_t byte_to_word(input logic [6:0] byte_addr);
	return smpc_pkg::addr_t'(byte_addr >> 1);
endfunction

task automatic bus_write(input smpc_pkg::addr_t addr, input smpc_pkg::byte_t data);
	@(negedge CLK);
	a    = addr;
	din  = data;
	cs_n = 1'b0;
	@(negedge CLK);
	rw_n = 1'b0; // Write taken on this fall
	@(negedge CLK);
	rw_n = 1'b1;
	cs_n = 1'b1;
endtask

task automatic bus_read(input smpc_pkg::addr_t addr, output smpc_pkg::byte_t data);
	@(negedge CLK);
	a    = addr;
	rw_n = 1'b1;
	cs_n = 1'b0;
	@(negedge CLK);
	data = dout;
	cs_n = 1'b1;
endtask

task automatic write_ireg(input int idx, input smpc_pkg::byte_t data);
	bus_write(byte_to_word(smpc_pkg::ADDR_IREG0 + 7'(2 * idx)), data);
endtask

task automatic read_oreg(input int idx, output smpc_pkg::byte_t data);
	bus_read(byte_to_word(smpc_pkg::ADDR_OREG_FIRST + 7'(2 * idx)), data);
endtask

task automatic read_outputs();
	for (int i = 0; i < 32; i++)
		read_oreg(i, outputs[i]);
endtask

task automatic wait_idle(input smpc_pkg::byte_t cmd);
	smpc_pkg::byte_t sf;
	int              polls;
	polls = 0;
	bus_read(byte_to_word(smpc_pkg::ADDR_SF), sf);
	while (sf[0] && polls < POLL_LIMIT) begin
		bus_read(byte_to_word(smpc_pkg::ADDR_SF), sf);
		polls++;
	end
	if (sf[0]) begin
		errors++;
		$display("command %02h never finished, SF still set after %0d polls", cmd, polls);
	end
endtask

task automatic run_command(input smpc_pkg::byte_t cmd);
	bus_write(byte_to_word(smpc_pkg::ADDR_COMREG), cmd);
	wait_idle(cmd);
endtask

task automatic command_echo(input smpc_pkg::byte_t cmd);
	smpc_pkg::byte_t echo;
	run_command(cmd);
	read_oreg(int'(smpc_pkg::OREG_LAST), echo);
	check_value($sformatf("echo of command %02h", cmd), echo, cmd);
endtask

`endif

//--- tests/smpc_tb.sv
`timescale 1ns/1ns

module smpc_tb;

	localparam int TICKS_PER_SEC = 2000;
	localparam int WAIT_SUM = int'(smpc_pkg::WAIT_ACCEPT) + int'(smpc_pkg::WAIT_LINE) +
		int'(smpc_pkg::WAIT_CD) + int'(smpc_pkg::WAIT_NMI) +
		int'(smpc_pkg::WAIT_SETTIME) + int'(smpc_pkg::WAIT_INTBACK);
	localparam int WATCHDOG_CYCLES = 20 * (WAIT_SUM + 2 * TICKS_PER_SEC);

	logic            CLK;
	logic            RST_N;
	logic            mres_n;
	logic            time_set;
	logic [3:0]      ac;
	smpc_pkg::addr_t a;
	smpc_pkg::byte_t din;
	smpc_pkg::byte_t dout;
	logic            cs_n;
	logic            rw_n;
	logic            msh_res_n;
	logic            msh_nmi_n;
	logic            ssh_res_n;
	logic            ssh_nmi_n;
	logic            sys_res_n;
	logic            snd_res_n;
	logic            cd_res_n;
	logic            mirq_n;
	logic [7:0]      lines;

	int              seed = 32'h9e4;
	int              checks = 0;
	int              errors = 0;
	int              prop_errors = 0;
	int              mirq_low_cycles = 0;
	int              nmi_low_cycles = 0;
	smpc_pkg::byte_t outputs [32];
	smpc_pkg::byte_t snapshot [32];

	assign lines = {msh_res_n, msh_nmi_n, ssh_res_n, ssh_nmi_n,
		sys_res_n, snd_res_n, cd_res_n, mirq_n};

	tb_clock #(.PERIOD(40)) u_clock (.CLK(CLK), .RST_N(RST_N));

	smpc_top #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_dut (
		.CLK(CLK), .RST_N(RST_N), .ce(1'b1), .mres_n(mres_n), .time_set(time_set),
		.ac(ac), .a(a), .din(din), .dout(dout), .cs_n(cs_n), .rw_n(rw_n),
		.msh_res_n(msh_res_n), .msh_nmi_n(msh_nmi_n), .ssh_res_n(ssh_res_n),
		.ssh_nmi_n(ssh_nmi_n), .sys_res_n(sys_res_n), .snd_res_n(snd_res_n),
		.cd_res_n(cd_res_n), .mirq_n(mirq_n)
	);

	`include "smpc_tb_tasks.svh"

	always @(posedge CLK) begin
		if (RST_N && mirq_n === 1'b0)
			mirq_low_cycles <= mirq_low_cycles + 1;
	end

	always @(posedge CLK) begin
		if (RST_N && msh_nmi_n === 1'b0)
			nmi_low_cycles <= nmi_low_cycles + 1;
	end

	// Host interrupt is a single-cycle pulse
	mirq_pulse_width: assert property (@(posedge CLK) disable iff (!RST_N)
		$fell(mirq_n) |=> mirq_n)
	else begin
		prop_errors++;
		$display("mismatch at %0t: mirq_n held low for more than one cycle", $time);
	end

	function automatic int pick(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic smpc_pkg::byte_t to_bcd(input int v);
		return smpc_pkg::byte_t'(((v / 10) << 4) + (v % 10));
	endfunction

	task automatic check_value(input string what, input int got, input int expected);
		checks++;
		assert (got == expected)
		else begin
			errors++;
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic set_time(input smpc_pkg::byte_t yh, input smpc_pkg::byte_t yl,
		input smpc_pkg::byte_t dm, input smpc_pkg::byte_t dd, input smpc_pkg::byte_t hh,
		input smpc_pkg::byte_t mm, input smpc_pkg::byte_t ss);
		write_ireg(0, yh);
		write_ireg(1, yl);
		write_ireg(2, dm);
		write_ireg(3, dd);
		write_ireg(4, hh);
		write_ireg(5, mm);
		write_ireg(6, ss);
		command_echo(smpc_pkg::CMD_SETTIME);
	endtask

	task automatic status_intback();
		write_ireg(0, 8'h01); // Status request bit
		write_ireg(2, smpc_pkg::INTBACK_KEY);
		command_echo(smpc_pkg::CMD_INTBACK);
		read_outputs();
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

	initial begin
		smpc_pkg::byte_t rd;
		smpc_pkg::byte_t yh;
		smpc_pkg::byte_t yl;
		smpc_pkg::byte_t dm;
		smpc_pkg::byte_t dd;
		smpc_pkg::byte_t hh;
		smpc_pkg::byte_t mm;
		int              sec_val;
		int              m0;
		int              n0;

		a        = '0;
		din      = '0;
		cs_n     = 1'b1;
		rw_n     = 1'b1;
		mres_n   = 1'b0;
		time_set = 1'b0;
		ac       = 4'(pick(16));

		@(posedge CLK);
		@(negedge CLK);
		check_value("lines in reset", lines, 8'b0000_0001);
		wait (RST_N === 1'b1);
		repeat (2) @(negedge CLK);
		check_value("lines with mres_n low", lines, 8'b1101_1011);
		mres_n = 1'b1;

		bus_read(byte_to_word(smpc_pkg::ADDR_SF), rd);
		check_value("SF after reset", rd, 8'hF0);
		write_ireg(1, 8'hA5);
		bus_read(byte_to_word(smpc_pkg::ADDR_SR), rd);
		check_value("SR with ireg1 = A5", rd, 8'h0A);
		bus_write(byte_to_word(smpc_pkg::ADDR_SF), 8'h01);
		bus_read(byte_to_word(smpc_pkg::ADDR_SF), rd);
		check_value("SF after host set", rd, 8'hF1);

		command_echo(smpc_pkg::CMD_SSHON);
		check_value("ssh_res_n after SSHON", ssh_res_n, 1);
		command_echo(smpc_pkg::CMD_SSHOFF);
		check_value("ssh_res_n after SSHOFF", ssh_res_n, 0);
		command_echo(smpc_pkg::CMD_SNDON);
		check_value("snd_res_n after SNDON", snd_res_n, 1);
		command_echo(smpc_pkg::CMD_SNDOFF);
		check_value("snd_res_n after SNDOFF", snd_res_n, 0);
		if (pick(2) == 0) begin
			command_echo(smpc_pkg::CMD_SNDON);
			check_value("snd_res_n after SNDON", snd_res_n, 1);
		end
		command_echo(smpc_pkg::CMD_CDOFF);
		check_value("cd_res_n after CDOFF", cd_res_n, 0);
		command_echo(smpc_pkg::CMD_CDON);
		check_value("cd_res_n after CDON", cd_res_n, 1);
		if (pick(2) == 0) begin
			command_echo(smpc_pkg::CMD_CDOFF);
			check_value("cd_res_n after CDOFF", cd_res_n, 0);
		end
		command_echo(smpc_pkg::CMD_MSHON);
		check_value("msh_res_n after MSHON", msh_res_n, 1);
		n0 = nmi_low_cycles;
		command_echo(smpc_pkg::CMD_NMIREQ);
		check_value("main NMI pulsed by NMIREQ", nmi_low_cycles > n0, 1);
		check_value("msh_nmi_n after NMIREQ", msh_nmi_n, 1);

		command_echo(smpc_pkg::CMD_RESENAB);
		yh      = to_bcd(pick(100));
		yl      = to_bcd(pick(100));
		dm      = {4'(pick(7)), 4'(1 + pick(12))}; // Weekday and binary month
		dd      = to_bcd(1 + pick(28));
		hh      = to_bcd(pick(24));
		mm      = to_bcd(pick(60));
		sec_val = pick(59); // No minute carry
		set_time(yh, yl, dm, dd, hh, mm, to_bcd(sec_val));
		m0 = mirq_low_cycles;
		status_intback();
		check_value("status byte 0", outputs[0], 8'h80);
		check_value("year high", outputs[1], yh);
		check_value("year low", outputs[2], yl);
		check_value("day/month", outputs[3], dm);
		check_value("days", outputs[4], dd);
		check_value("hour", outputs[5], hh);
		check_value("minute", outputs[6], mm);
		check_value("second within one tick", outputs[7] == to_bcd(sec_val) ||
			outputs[7] == to_bcd(sec_val + 1), 1);
		check_value("area code", outputs[9], ac);
		check_value("mirq_n low pulses", mirq_low_cycles - m0, 1);
		bus_read(byte_to_word(smpc_pkg::ADDR_SR), rd);
		check_value("SR bits 7:6", rd[7:6], 2'b01);

		set_time(8'h19, 8'h99, 8'h0C, 8'h31, 8'h23, 8'h59, 8'h59);
		repeat (2 * TICKS_PER_SEC) @(posedge CLK);
		status_intback();
		check_value("year high after new year", outputs[1], 8'h20);
		check_value("year low after new year", outputs[2], 8'h00);
		check_value("month after new year", outputs[3], 8'h01);
		check_value("days after new year", outputs[4], 8'h01);
		check_value("hour after new year", outputs[5], 8'h00);
		set_time(8'h20, 8'h23, 8'h02, 8'h28, 8'h23, 8'h59, 8'h59);
		repeat (2 * TICKS_PER_SEC) @(posedge CLK);
		status_intback();
		check_value("month after Feb 28", outputs[3], 8'h03);
		check_value("days after Feb 28", outputs[4], 8'h01);

		command_echo(smpc_pkg::CMD_RESDISA);
		read_outputs();
		snapshot = outputs;
		write_ireg(2, 8'h00);
		m0 = mirq_low_cycles;
		run_command(smpc_pkg::CMD_INTBACK);
		read_outputs();
		check_value("echo of rejected INTBACK", outputs[31], smpc_pkg::CMD_INTBACK);
		for (int i = 0; i < 31; i++)
			check_value($sformatf("output %0d after rejected INTBACK", i), outputs[i],
				snapshot[i]);
		check_value("mirq_n pulses on rejected INTBACK", mirq_low_cycles - m0, 0);

		$display("checks %0d, check errors %0d, assertion errors %0d",
			checks, errors, prop_errors);
		if (errors == 0 && prop_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic CLK,
	output logic RST_N
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		RST_N = 1'b0;
		#(2 * PERIOD) RST_N = 1'b1; // Released on a falling edge
	end

endmodule

//--- verilog/smpc_top.sv
`timescale 1ns/1ns

module smpc_top #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              ce,
	input  logic              mres_n,
	input  logic              time_set,
	input  logic [3:0]        ac,
	input  smpc_pkg::addr_t   a,
	input  smpc_pkg::byte_t   din,
	output smpc_pkg::byte_t   dout,
	input  logic              cs_n,
	input  logic              rw_n,
	output logic              msh_res_n,
	output logic              msh_nmi_n,
	output logic              ssh_res_n,
	output logic              ssh_nmi_n,
	output logic              sys_res_n,
	output logic              snd_res_n,
	output logic              cd_res_n,
	output logic              mirq_n
);

	smpc_pkg::byte_t      ireg [smpc_pkg::IREG_COUNT];
	smpc_pkg::byte_t      comreg;
	logic                 cmd_strobe;
	logic                 sf_clear;
	logic                 status_done;
	logic                 rtc_load;
	smpc_pkg::oreg_addr_t oreg_ra;
	smpc_pkg::byte_t      oreg_q;
	logic                 oreg_we;
	smpc_pkg::oreg_addr_t oreg_wa;
	smpc_pkg::byte_t      oreg_wd;
	smpc_pkg::bcd_t       sec;
	smpc_pkg::bcd_t       min;
	smpc_pkg::bcd_t       hour;
	smpc_pkg::bcd_t       days;
	smpc_pkg::bcd_t       day_month;
	smpc_pkg::year_t      year;

	smpc_host_regs u_host_regs (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.mres_n      (mres_n),
		.a           (a),
		.din         (din),
		.dout        (dout),
		.cs_n        (cs_n),
		.rw_n        (rw_n),
		.oreg_ra     (oreg_ra),
		.oreg_q      (oreg_q),
		.ireg        (ireg),
		.comreg      (comreg),
		.cmd_strobe  (cmd_strobe),
		.sf_clear    (sf_clear),
		.status_done (status_done)
	);

	smpc_cmd_seq u_cmd_seq (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.ce          (ce),
		.mres_n      (mres_n),
		.time_set    (time_set),
		.ac          (ac),
		.cmd_strobe  (cmd_strobe),
		.comreg      (comreg),
		.ireg        (ireg),
		.sec         (sec),
		.min         (min),
		.hour        (hour),
		.days        (days),
		.day_month   (day_month),
		.year        (year),
		.msh_res_n   (msh_res_n),
		.msh_nmi_n   (msh_nmi_n),
		.ssh_res_n   (ssh_res_n),
		.ssh_nmi_n   (ssh_nmi_n),
		.sys_res_n   (sys_res_n),
		.snd_res_n   (snd_res_n),
		.cd_res_n    (cd_res_n),
		.mirq_n      (mirq_n),
		.oreg_we     (oreg_we),
		.oreg_wa     (oreg_wa),
		.oreg_wd     (oreg_wd),
		.sf_clear    (sf_clear),
		.status_done (status_done),
		.rtc_load    (rtc_load)
	);

	smpc_rtc #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) u_rtc (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ce        (ce),
		.rtc_load  (rtc_load),
		.ireg      (ireg),
		.sec       (sec),
		.min       (min),
		.hour      (hour),
		.days      (days),
		.day_month (day_month),
		.year      (year)
	);

	smpc_oreg_ram u_oreg_ram (
		.CLK (CLK),
		.we  (oreg_we),
		.wa  (oreg_wa),
		.wd  (oreg_wd),
		.ra  (oreg_ra),
		.q   (oreg_q)
	);

endmodule

//--- rtc/smpc_rtc.sv
`timescale 1ns/1ns

module smpc_rtc #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic            CLK,
	input  logic            RST_N,
	input  logic            ce,
	input  logic            rtc_load,
	input  smpc_pkg::byte_t ireg [smpc_pkg::IREG_COUNT],
	output smpc_pkg::bcd_t  sec,
	output smpc_pkg::bcd_t  min,
	output smpc_pkg::bcd_t  hour,
	output smpc_pkg::bcd_t  days,
	output smpc_pkg::bcd_t  day_month,
	output smpc_pkg::year_t year
);

	localparam int CNT_W = $clog2(TICKS_PER_SEC + 1);

	logic [CNT_W-1:0] tick_cnt;
	logic             sec_tick;
	logic             min_tick;
	logic             hour_tick;
	logic             day_tick;
	logic             mon_tick;
	logic             year_tick;

	function automatic smpc_pkg::bcd_t bcd_inc(smpc_pkg::bcd_t v);
		if (v[3:0] == 4'd9)
			return {v[7:4] + 4'd1, 4'd0};
		return v + 8'd1;
	endfunction

	function automatic smpc_pkg::bcd_t month_last(logic [3:0] month);
		case (month)
			4'd2:                    return 8'h28;
			4'd4, 4'd6, 4'd9, 4'd11: return 8'h30;
			default:                 return 8'h31;
		endcase
	endfunction

	function automatic smpc_pkg::year_t year_inc(smpc_pkg::year_t y);
		smpc_pkg::bcd_t hi;
		smpc_pkg::bcd_t lo;
		hi = y[15:8];
		lo = y[7:0];
		if (lo == 8'h99) begin
			lo = 8'h00;
			hi = (hi == 8'h99) ? 8'h00 : bcd_inc(hi);
		end else
			lo = bcd_inc(lo);
		return {hi, lo};
	endfunction

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tick_cnt  <= '0;
			sec_tick  <= 1'b0;
			min_tick  <= 1'b0;
			hour_tick <= 1'b0;
			day_tick  <= 1'b0;
			mon_tick  <= 1'b0;
			year_tick <= 1'b0;
			sec       <= smpc_pkg::RTC_TIME_INIT;
			min       <= smpc_pkg::RTC_TIME_INIT;
			hour      <= smpc_pkg::RTC_TIME_INIT;
			days      <= smpc_pkg::RTC_DAYS_INIT;
			day_month <= smpc_pkg::RTC_DAY_MONTH_INIT;
			year      <= smpc_pkg::RTC_YEAR_INIT;
		end else if (rtc_load) begin
			tick_cnt  <= '0; // Restart the second on a new time
			sec_tick  <= 1'b0;
			min_tick  <= 1'b0;
			hour_tick <= 1'b0;
			day_tick  <= 1'b0;
			mon_tick  <= 1'b0;
			year_tick <= 1'b0;
			sec       <= ireg[6];
			min       <= ireg[5];
			hour      <= ireg[4];
			days      <= ireg[3];
			day_month <= ireg[2];
			year      <= {ireg[0], ireg[1]};
		end else if (ce) begin
			sec_tick  <= 1'b0;
			min_tick  <= 1'b0;
			hour_tick <= 1'b0;
			day_tick  <= 1'b0;
			mon_tick  <= 1'b0;
			year_tick <= 1'b0;

			if (tick_cnt == CNT_W'(TICKS_PER_SEC - 1)) begin
				tick_cnt <= '0;
				sec_tick <= 1'b1;
			end else
				tick_cnt <= tick_cnt + 1'b1;

			// Each carry reaches the next field one cycle later
			if (sec_tick) begin
				sec <= (sec == 8'h59) ? 8'h00 : bcd_inc(sec);
				min_tick <= (sec == 8'h59);
			end
			if (min_tick) begin
				min <= (min == 8'h59) ? 8'h00 : bcd_inc(min);
				hour_tick <= (min == 8'h59);
			end
			if (hour_tick) begin
				hour <= (hour == 8'h23) ? 8'h00 : bcd_inc(hour);
				day_tick <= (hour == 8'h23);
			end
			if (day_tick) begin
				if (days == month_last(day_month[3:0])) begin
					days     <= 8'h01;
					mon_tick <= 1'b1;
				end else
					days <= bcd_inc(days);
			end
			if (mon_tick) begin
				if (day_month[3:0] == 4'd12) begin // Month nibble is binary
					day_month[3:0] <= 4'd1;
					year_tick      <= 1'b1;
				end else
					day_month[3:0] <= day_month[3:0] + 4'd1;
			end
			if (year_tick)
				year <= year_inc(year);
		end
	end

endmodule

//--- command/smpc_cmd_seq.sv
`timescale 1ns/1ns

module smpc_cmd_seq (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 ce,
	input  logic                 mres_n,
	input  logic                 time_set,
	input  logic [3:0]           ac,
	input  logic                 cmd_strobe,
	input  smpc_pkg::byte_t      comreg,
	input  smpc_pkg::byte_t      ireg [smpc_pkg::IREG_COUNT],
	input  smpc_pkg::bcd_t       sec,
	input  smpc_pkg::bcd_t       min,
	input  smpc_pkg::bcd_t       hour,
	input  smpc_pkg::bcd_t       days,
	input  smpc_pkg::bcd_t       day_month,
	input  smpc_pkg::year_t      year,
	output logic                 msh_res_n,
	output logic                 msh_nmi_n,
	output logic                 ssh_res_n,
	output logic                 ssh_nmi_n,
	output logic                 sys_res_n,
	output logic                 snd_res_n,
	output logic                 cd_res_n,
	output logic                 mirq_n,
	output logic                 oreg_we,
	output smpc_pkg::oreg_addr_t oreg_wa,
	output smpc_pkg::byte_t      oreg_wd,
	output logic                 sf_clear,
	output logic                 status_done,
	output logic                 rtc_load
);

	smpc_pkg::cmd_state_t state;
	smpc_pkg::cmd_state_t next_state;
	smpc_pkg::wait_t      wait_cnt;
	smpc_pkg::oreg_addr_t oreg_cnt;
	smpc_pkg::byte_t      status_byte;
	logic                 pending;
	logic                 status_req;
	logic                 resd;
	logic                 ste;

	always_comb begin
		case (oreg_cnt)
			5'd0:  status_byte = {ste, resd, 6'b000000};
			5'd1:  status_byte = year[15:8];
			5'd2:  status_byte = year[7:0];
			5'd3:  status_byte = day_month;
			5'd4:  status_byte = days;
			5'd5:  status_byte = hour;
			5'd6:  status_byte = min;
			5'd7:  status_byte = sec;
			5'd9:  status_byte = {4'b0000, ac};
			// Dot select fixed at 320
			5'd10: status_byte = {2'b00, 2'b11, ~msh_nmi_n, 1'b1, ~sys_res_n, ~snd_res_n};
			5'd11: status_byte = {1'b0, ~cd_res_n, 6'b000000};
			5'd31: status_byte = comreg;
			default: status_byte = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state       <= smpc_pkg::IDLE;
			next_state  <= smpc_pkg::IDLE;
			wait_cnt    <= '0;
			oreg_cnt    <= '0;
			pending     <= 1'b0;
			status_req  <= 1'b0;
			msh_res_n   <= 1'b0;
			msh_nmi_n   <= 1'b0;
			ssh_res_n   <= 1'b0;
			ssh_nmi_n   <= 1'b0;
			sys_res_n   <= 1'b0;
			snd_res_n   <= 1'b0;
			cd_res_n    <= 1'b0;
			mirq_n      <= 1'b1;
			resd        <= 1'b1;
			ste         <= 1'b0;
			oreg_we     <= 1'b0;
			oreg_wa     <= '0;
			oreg_wd     <= '0;
			sf_clear    <= 1'b0;
			status_done <= 1'b0;
			rtc_load    <= 1'b0;
		end else begin
			oreg_we     <= 1'b0;
			sf_clear    <= 1'b0;
			status_done <= 1'b0;
			rtc_load    <= 1'b0;

			if (!mres_n) begin
				msh_res_n  <= 1'b1;
				msh_nmi_n  <= 1'b1;
				ssh_res_n  <= 1'b0;
				ssh_nmi_n  <= 1'b1;
				sys_res_n  <= 1'b1;
				snd_res_n  <= 1'b0;
				cd_res_n   <= 1'b1;
				mirq_n     <= 1'b1;
				resd       <= 1'b1;
				ste        <= time_set;
				state      <= smpc_pkg::IDLE;
				pending    <= 1'b0;
				status_req <= 1'b0;
			end else if (ce) begin
				case (state)
					smpc_pkg::IDLE: begin
						if (pending) begin
							pending    <= 1'b0;
							wait_cnt   <= smpc_pkg::WAIT_ACCEPT;
							next_state <= smpc_pkg::COMMAND;
							state      <= smpc_pkg::WAIT;
						end
					end

					smpc_pkg::WAIT: begin
						if (wait_cnt == '0)
							state <= next_state;
						else
							wait_cnt <= wait_cnt - 16'd1;
					end

					smpc_pkg::COMMAND: begin
						next_state <= smpc_pkg::EXEC;
						state      <= smpc_pkg::WAIT;
						status_req <= 1'b0;
						case (comreg)
							smpc_pkg::CMD_MSHON, smpc_pkg::CMD_SSHON, smpc_pkg::CMD_SSHOFF,
							smpc_pkg::CMD_SNDON, smpc_pkg::CMD_SNDOFF:
								wait_cnt <= smpc_pkg::WAIT_LINE;
							smpc_pkg::CMD_CDON, smpc_pkg::CMD_CDOFF:
								wait_cnt <= smpc_pkg::WAIT_CD;
							smpc_pkg::CMD_NMIREQ, smpc_pkg::CMD_RESENAB, smpc_pkg::CMD_RESDISA:
								wait_cnt <= smpc_pkg::WAIT_NMI;
							smpc_pkg::CMD_SETTIME:
								wait_cnt <= smpc_pkg::WAIT_SETTIME;
							smpc_pkg::CMD_INTBACK: begin
								if (ireg[2] == smpc_pkg::INTBACK_KEY && ireg[0][0]) begin
									wait_cnt   <= smpc_pkg::WAIT_INTBACK;
									status_req <= 1'b1;
								end else
									state <= smpc_pkg::EXEC; // Echo only
							end
							default: state <= smpc_pkg::EXEC;
						endcase
					end

					smpc_pkg::EXEC: begin
						oreg_we <= 1'b1;
						oreg_wa <= smpc_pkg::OREG_LAST;
						oreg_wd <= comreg;
						state   <= smpc_pkg::END;
						case (comreg)
							smpc_pkg::CMD_MSHON: begin
								msh_res_n <= 1'b1;
								msh_nmi_n <= 1'b1;
							end
							smpc_pkg::CMD_SSHON: begin
								ssh_res_n <= 1'b1;
								ssh_nmi_n <= 1'b1;
							end
							smpc_pkg::CMD_SSHOFF: begin
								ssh_res_n <= 1'b0;
								ssh_nmi_n <= 1'b1;
							end
							smpc_pkg::CMD_SNDON:   snd_res_n <= 1'b1;
							smpc_pkg::CMD_SNDOFF:  snd_res_n <= 1'b0;
							smpc_pkg::CMD_CDON:    cd_res_n  <= 1'b1;
							smpc_pkg::CMD_CDOFF:   cd_res_n  <= 1'b0;
							smpc_pkg::CMD_NMIREQ:  msh_nmi_n <= 1'b0;
							smpc_pkg::CMD_RESENAB: resd      <= 1'b0;
							smpc_pkg::CMD_RESDISA: resd      <= 1'b1;
							smpc_pkg::CMD_SETTIME: begin
								rtc_load <= 1'b1;
								ste      <= 1'b1;
							end
							smpc_pkg::CMD_INTBACK: begin
								if (status_req) begin
									oreg_cnt <= '0;
									state    <= smpc_pkg::STATUS;
								end
							end
							default: ;
						endcase
					end

					smpc_pkg::STATUS: begin
						oreg_we  <= 1'b1;
						oreg_wa  <= oreg_cnt;
						oreg_wd  <= status_byte;
						oreg_cnt <= oreg_cnt + 5'd1;
						if (oreg_cnt == smpc_pkg::OREG_LAST) begin
							mirq_n      <= 1'b0; // Low for the END cycle
							status_done <= 1'b1;
							state       <= smpc_pkg::END;
						end
					end

					smpc_pkg::END: begin
						sf_clear <= 1'b1;
						mirq_n   <= 1'b1;
						if (comreg == smpc_pkg::CMD_NMIREQ)
							msh_nmi_n <= 1'b1;
						state <= smpc_pkg::IDLE;
					end

					default: state <= smpc_pkg::IDLE;
				endcase
			end

			if (cmd_strobe && mres_n)
				pending <= 1'b1; // Runs once back in IDLE
		end
	end

endmodule

//--- verilog/smpc_host_regs.sv
`timescale 1ns/1ns

module smpc_host_regs (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 mres_n,
	input  smpc_pkg::addr_t      a,
	input  smpc_pkg::byte_t      din,
	output smpc_pkg::byte_t      dout,
	input  logic                 cs_n,
	input  logic                 rw_n,
	output smpc_pkg::oreg_addr_t oreg_ra,
	input  smpc_pkg::byte_t      oreg_q,
	output smpc_pkg::byte_t      ireg [smpc_pkg::IREG_COUNT],
	output smpc_pkg::byte_t      comreg,
	output logic                 cmd_strobe,
	input  logic                 sf_clear,
	input  logic                 status_done
);

	logic            rw_n_old;
	logic            cs_n_old;
	logic            wr_hit;
	logic            rd_hit;
	logic [6:0]      byte_addr;
	smpc_pkg::addr_t ra_word;
	logic            sf;
	logic [1:0]      sr_top;
	smpc_pkg::byte_t sr;
	smpc_pkg::byte_t rd_data;

	assign byte_addr = {a, 1'b1};
	assign wr_hit    = !rw_n && rw_n_old && !cs_n; // Falling RW_N inside a select
	assign rd_hit    = !cs_n && cs_n_old && rw_n;

	// OREG window starts at word 0x10
	assign ra_word = a - smpc_pkg::addr_t'(smpc_pkg::ADDR_OREG_FIRST >> 1);
	assign oreg_ra = ra_word[4:0];

	assign sr = {sr_top, 2'b00, ireg[1][7:4]};

	always_comb begin
		rd_data = '0;
		if (byte_addr >= smpc_pkg::ADDR_OREG_FIRST && byte_addr <= smpc_pkg::ADDR_OREG_LAST)
			rd_data = oreg_q;
		else if (byte_addr == smpc_pkg::ADDR_SR)
			rd_data = sr;
		else if (byte_addr == smpc_pkg::ADDR_SF)
			rd_data = {7'b1111000, sf};
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old   <= 1'b1;
			cs_n_old   <= 1'b1;
			for (int i = 0; i < smpc_pkg::IREG_COUNT; i++)
				ireg[i] <= '0;
			comreg     <= '0;
			cmd_strobe <= 1'b0;
			sf         <= 1'b0;
			sr_top     <= 2'b00;
			dout       <= '0;
		end else begin
			rw_n_old   <= rw_n;
			cs_n_old   <= cs_n;
			cmd_strobe <= 1'b0;

			if (!mres_n)
				sr_top <= 2'b00;
			else if (status_done)
				sr_top <= 2'b01; // Status data ready

			if (sf_clear)
				sf <= 1'b0;

			if (wr_hit) begin
				if (byte_addr >= smpc_pkg::ADDR_IREG0 &&
				    byte_addr < smpc_pkg::ADDR_IREG0 + 7'(2 * smpc_pkg::IREG_COUNT))
					ireg[a[2:0]] <= din;
				else if (byte_addr == smpc_pkg::ADDR_COMREG) begin
					comreg     <= din;
					cmd_strobe <= 1'b1;
					sf         <= 1'b1;
				end else if (byte_addr == smpc_pkg::ADDR_SF && din[0])
					sf <= 1'b1;
			end

			if (rd_hit)
				dout <= rd_data; // Held until the next read
		end
	end

endmodule

//--- verilog/smpc_oreg_ram.sv
`timescale 1ns/1ns

module smpc_oreg_ram (
	input  logic                 CLK,
	input  logic                 we,
	input  smpc_pkg::oreg_addr_t wa,
	input  smpc_pkg::byte_t      wd,
	input  smpc_pkg::oreg_addr_t ra,
	output smpc_pkg::byte_t      q
);

	smpc_pkg::byte_t mem [32];

	always_ff @(posedge CLK) begin
		if (we)
			mem[wa] <= wd;
	end

	assign q = mem[ra]; // Asynchronous read port

endmodule

//--- common/smpc_pkg.sv
package smpc_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  bcd_t;
	typedef logic [15:0] year_t;
	typedef logic [5:0]  addr_t;
	typedef logic [4:0]  oreg_addr_t;
	typedef logic [15:0] wait_t;

	localparam int         IREG_COUNT = 7;
	localparam oreg_addr_t OREG_LAST  = 5'd31; // Holds the echoed command

	// Host byte addresses, always odd on the bus
	localparam logic [6:0] ADDR_IREG0      = 7'h01;
	localparam logic [6:0] ADDR_COMREG     = 7'h1F;
	localparam logic [6:0] ADDR_OREG_FIRST = 7'h21;
	localparam logic [6:0] ADDR_OREG_LAST  = 7'h5F;
	localparam logic [6:0] ADDR_SR         = 7'h61;
	localparam logic [6:0] ADDR_SF         = 7'h63;

	localparam byte_t CMD_MSHON   = 8'h00;
	localparam byte_t CMD_SSHON   = 8'h02;
	localparam byte_t CMD_SSHOFF  = 8'h03;
	localparam byte_t CMD_SNDON   = 8'h06;
	localparam byte_t CMD_SNDOFF  = 8'h07;
	localparam byte_t CMD_CDON    = 8'h08;
	localparam byte_t CMD_CDOFF   = 8'h09;
	localparam byte_t CMD_INTBACK = 8'h10;
	localparam byte_t CMD_SETTIME = 8'h16;
	localparam byte_t CMD_NMIREQ  = 8'h18;
	localparam byte_t CMD_RESENAB = 8'h19;
	localparam byte_t CMD_RESDISA = 8'h1A;

	// Counted in enabled cycles
	localparam wait_t WAIT_ACCEPT  = 16'd90;
	localparam wait_t WAIT_LINE    = 16'd120;
	localparam wait_t WAIT_CD      = 16'd159;
	localparam wait_t WAIT_NMI     = 16'd127;
	localparam wait_t WAIT_SETTIME = 16'd279;
	localparam wait_t WAIT_INTBACK = 16'd800;

	localparam byte_t INTBACK_KEY = 8'hF0; // Required in input register 2

	typedef enum logic [2:0] {
		IDLE,
		WAIT,
		COMMAND,
		EXEC,
		STATUS,
		END
	} cmd_state_t;

	localparam year_t RTC_YEAR_INIT      = 16'h2024;
	localparam bcd_t  RTC_DAY_MONTH_INIT = 8'h01; // Weekday 0, January
	localparam bcd_t  RTC_DAYS_INIT      = 8'h01;
	localparam bcd_t  RTC_TIME_INIT      = 8'h00;

endpackage
